//--- design/soc_map_pkg.sv
package soc_map_pkg;

   // APB address
   localparam int ADDR_W = 12;

   //*********************************************************************
   // Region field, one region per 256 bytes
   //*********************************************************************
   localparam int REGION_MSB = 11;
   localparam int REGION_LSB = 8;
   localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

   localparam logic [REGION_W-1:0] REGION_GPIO = 4'd0;
   localparam logic [REGION_W-1:0] REGION_SYS  = 4'd1;

   // Word index inside a region
   localparam int REG_IDX_W   = 3;
   localparam int REG_IDX_LSB = 2;
   localparam int REG_IDX_MSB = REG_IDX_LSB + REG_IDX_W - 1;

   // GPIO bank
   localparam logic [REG_IDX_W-1:0] GPIO_DATA_IN  = 3'd0;
   localparam logic [REG_IDX_W-1:0] GPIO_DATA_OUT = 3'd1;
   localparam logic [REG_IDX_W-1:0] GPIO_OUT_EN   = 3'd2;
   localparam logic [REG_IDX_W-1:0] GPIO_IRQ_MASK = 3'd3;
   localparam logic [REG_IDX_W-1:0] GPIO_IRQ_STAT = 3'd4;

   // System controller
   localparam logic [REG_IDX_W-1:0] SYS_MTIME    = 3'd0;
   localparam logic [REG_IDX_W-1:0] SYS_MTIMECMP = 3'd1;
   localparam logic [REG_IDX_W-1:0] SYS_CTRL     = 3'd2;
   localparam logic [REG_IDX_W-1:0] SYS_IRQ_PEND = 3'd3;

endpackage

//--- design/periph_pkg.sv
package periph_pkg;

   localparam int DATA_W = 32;
   localparam int GPIO_W = 32;
   localparam int IRQ_W  = 8;

   //*********************************************************************
   // External interrupt vector, bits 6 and 7 unused
   //*********************************************************************
   localparam int IRQ_UART  = 0;
   localparam int IRQ_SPI   = 1;
   localparam int IRQ_SW3   = 2;
   localparam int IRQ_SW4   = 3;
   localparam int IRQ_GPIO  = 4;
   localparam int IRQ_TIMER = 5;

   // Control view of a system controller word
   typedef struct packed {
      logic [26:0] rsvd_hi;
      logic        sw_irq4;
      logic        sw_irq3;
      logic [2:0]  rsvd_lo;
   } sys_ctrl_t;

   // Same word as a raw count (MTIMECMP) or as CTRL bits
   typedef union packed {
      logic [DATA_W-1:0] count;
      sys_ctrl_t         ctrl;
   } sys_word_u;

endpackage

//--- design/apb_decode.sv
module apb_decode (
   input  logic                              i_psel,
   input  logic                              i_penable,
   input  logic                              i_pwrite,
   input  logic [soc_map_pkg::ADDR_W-1:0]    i_paddr,
   input  logic                              i_pready,
   output logic                              o_sel_gpio,
   output logic                              o_sel_sys,
   output logic [soc_map_pkg::REG_IDX_W-1:0] o_reg_idx,
   output logic                              o_wr_stb,
   output logic                              o_err
);

   import soc_map_pkg::*;

   logic [REGION_W-1:0] region;
   logic                hit_gpio;
   logic                hit_sys;
   logic                first_access;

   assign region    = i_paddr[REGION_MSB:REGION_LSB];
   assign o_reg_idx = i_paddr[REG_IDX_MSB:REG_IDX_LSB];

   assign hit_gpio = (region == REGION_GPIO);
   assign hit_sys  = (region == REGION_SYS);

   assign o_sel_gpio = i_psel && hit_gpio;
   assign o_sel_sys  = i_psel && hit_sys;

   // Anything outside the two regions
   assign o_err = i_psel && !(hit_gpio || hit_sys);

   //*********************************************************************
   // Write strobe
   //*********************************************************************

   // Ready is still low here, high in the repeated access cycle
   assign first_access = i_psel && i_penable && !i_pready;

   assign o_wr_stb = first_access && i_pwrite && (hit_gpio || hit_sys);

endmodule

//--- design/gpio_bank.sv
module gpio_bank (
   input  logic                              clk,
   input  logic                              i_rst_n,
   input  logic                              i_sel,
   input  logic [soc_map_pkg::REG_IDX_W-1:0] i_reg_idx,
   input  logic                              i_wr_stb,
   input  logic [periph_pkg::DATA_W-1:0]     i_wdata,
   input  logic [periph_pkg::GPIO_W-1:0]     i_gpio_in,
   output logic [periph_pkg::DATA_W-1:0]     o_rdata,
   output logic [periph_pkg::GPIO_W-1:0]     o_gpio_out,
   output logic [periph_pkg::GPIO_W-1:0]     o_gpio_oe,
   output logic                              o_gpio_irq
);

   import soc_map_pkg::*;
   import periph_pkg::*;

   logic [GPIO_W-1:0] gpio_meta;
   logic [GPIO_W-1:0] gpio_sync;
   logic [GPIO_W-1:0] gpio_prev;
   logic [GPIO_W-1:0] rise;
   logic [GPIO_W-1:0] irq_mask;
   logic [GPIO_W-1:0] irq_stat;
   logic [GPIO_W-1:0] stat_clr;
   logic              wr_en;

   assign wr_en = i_sel && i_wr_stb;

   //*********************************************************************
   // Pin synchroniser and edge detect
   //*********************************************************************
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         gpio_meta <= '0;
         gpio_sync <= '0;
         gpio_prev <= '0;
      end else begin
         gpio_meta <= i_gpio_in;
         gpio_sync <= gpio_meta;
         gpio_prev <= gpio_sync;
      end
   end

   assign rise = gpio_sync & ~gpio_prev;

   // Write one to clear
   assign stat_clr = (wr_en && (i_reg_idx == GPIO_IRQ_STAT)) ? i_wdata : '0;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_gpio_out <= '0;
         o_gpio_oe  <= '0;
         irq_mask   <= '0;
         irq_stat   <= '0;
      end else begin
         if (wr_en && (i_reg_idx == GPIO_DATA_OUT)) o_gpio_out <= i_wdata;
         if (wr_en && (i_reg_idx == GPIO_OUT_EN))   o_gpio_oe  <= i_wdata;
         if (wr_en && (i_reg_idx == GPIO_IRQ_MASK)) irq_mask   <= i_wdata;
         // A new edge wins over a clear in the same cycle
         irq_stat <= (irq_stat & ~stat_clr) | rise;
      end
   end

   assign o_gpio_irq = |(irq_stat & irq_mask);

   always_comb begin
      case (i_reg_idx)
         GPIO_DATA_IN:  o_rdata = gpio_sync;
         GPIO_DATA_OUT: o_rdata = o_gpio_out;
         GPIO_OUT_EN:   o_rdata = o_gpio_oe;
         GPIO_IRQ_MASK: o_rdata = irq_mask;
         GPIO_IRQ_STAT: o_rdata = irq_stat;
         default:       o_rdata = '0;
      endcase
   end

endmodule

//--- design/sys_ctrl.sv
module sys_ctrl (
   input  logic                              clk,
   input  logic                              i_rst_n,
   input  logic                              i_sel,
   input  logic [soc_map_pkg::REG_IDX_W-1:0] i_reg_idx,
   input  logic                              i_wr_stb,
   input  periph_pkg::sys_word_u             i_wdata,
   input  logic                              i_gpio_irq,
   output logic [periph_pkg::DATA_W-1:0]     o_rdata,
   output logic [periph_pkg::IRQ_W-1:0]      o_ext_irq
);

   import soc_map_pkg::*;
   import periph_pkg::*;

   logic [DATA_W-1:0] mtime;
   logic [DATA_W-1:0] mtimecmp;
   logic              sw_irq3;
   logic              sw_irq4;
   logic              timer_irq;
   logic              wr_en;
   sys_word_u         ctrl_rd;

   assign wr_en = i_sel && i_wr_stb;

   //*********************************************************************
   // Timer
   //*********************************************************************
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mtime <= '0;
      end else begin
         mtime <= mtime + 1'b1;
      end
   end

   // Compare starts at all ones so the timer stays quiet
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mtimecmp <= '1;
         sw_irq3  <= 1'b0;
         sw_irq4  <= 1'b0;
      end else begin
         if (wr_en && (i_reg_idx == SYS_MTIMECMP)) begin
            mtimecmp <= i_wdata.count;
         end
         if (wr_en && (i_reg_idx == SYS_CTRL)) begin
            sw_irq3 <= i_wdata.ctrl.sw_irq3;
            sw_irq4 <= i_wdata.ctrl.sw_irq4;
         end
      end
   end

   assign timer_irq = (mtime >= mtimecmp);

   //*********************************************************************
   // Interrupt vector
   //*********************************************************************
   always_comb begin
      o_ext_irq            = '0;
      o_ext_irq[IRQ_UART]  = 1'b0;
      o_ext_irq[IRQ_SPI]   = 1'b0;
      o_ext_irq[IRQ_SW3]   = sw_irq3;
      o_ext_irq[IRQ_SW4]   = sw_irq4;
      o_ext_irq[IRQ_GPIO]  = i_gpio_irq;
      o_ext_irq[IRQ_TIMER] = timer_irq;
   end

   always_comb begin
      ctrl_rd              = '0;
      ctrl_rd.ctrl.sw_irq3 = sw_irq3;
      ctrl_rd.ctrl.sw_irq4 = sw_irq4;
   end

   always_comb begin
      case (i_reg_idx)
         SYS_MTIME:    o_rdata = mtime;
         SYS_MTIMECMP: o_rdata = mtimecmp;
         SYS_CTRL:     o_rdata = ctrl_rd.count;
         SYS_IRQ_PEND: o_rdata = {{(DATA_W - IRQ_W){1'b0}}, o_ext_irq};
         default:      o_rdata = '0;
      endcase
   end

endmodule

//--- design/read_return.sv
module read_return (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic                          i_psel,
   input  logic                          i_penable,
   input  logic                          i_sel_gpio,
   input  logic                          i_sel_sys,
   input  logic                          i_err,
   input  logic [periph_pkg::DATA_W-1:0] i_gpio_rdata,
   input  logic [periph_pkg::DATA_W-1:0] i_sys_rdata,
   output logic [periph_pkg::DATA_W-1:0] o_prdata,
   output logic                          o_pready,
   output logic                          o_pslverr
);

   import periph_pkg::*;

   logic [DATA_W-1:0] rd_word;
   logic              first_access;

   // No region select on an error, so the word is 0 then
   always_comb begin
      if (i_sel_gpio) begin
         rd_word = i_gpio_rdata;
      end else if (i_sel_sys) begin
         rd_word = i_sys_rdata;
      end else begin
         rd_word = '0;
      end
   end

   assign first_access = i_psel && i_penable && !o_pready;

   // One wait state, then ready for a single cycle
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_prdata  <= '0;
         o_pready  <= 1'b0;
         o_pslverr <= 1'b0;
      end else if (first_access) begin
         o_prdata  <= rd_word;
         o_pready  <= 1'b1;
         o_pslverr <= i_err;
      end else begin
         o_pready  <= 1'b0;
         o_pslverr <= 1'b0;
      end
   end

endmodule

//--- design/periph_subsys.sv
module periph_subsys (
   input  logic                           clk,
   input  logic                           i_rst_n,
   input  logic                           i_psel,
   input  logic                           i_penable,
   input  logic                           i_pwrite,
   input  logic [soc_map_pkg::ADDR_W-1:0] i_paddr,
   input  logic [periph_pkg::DATA_W-1:0]  i_pwdata,
   output logic [periph_pkg::DATA_W-1:0]  o_prdata,
   output logic                           o_pready,
   output logic                           o_pslverr,
   input  logic [periph_pkg::GPIO_W-1:0]  i_gpio_in,
   output logic [periph_pkg::GPIO_W-1:0]  o_gpio_out,
   output logic [periph_pkg::GPIO_W-1:0]  o_gpio_oe,
   output logic [periph_pkg::IRQ_W-1:0]   o_ext_irq
);

   logic                              sel_gpio;
   logic                              sel_sys;
   logic [soc_map_pkg::REG_IDX_W-1:0] reg_idx;
   logic                              wr_stb;
   logic                              err;
   logic [periph_pkg::DATA_W-1:0]     gpio_rdata;
   logic [periph_pkg::DATA_W-1:0]     sys_rdata;
   logic                              gpio_irq;

   //*********************************************************************
   // Decode, register blocks, response
   //*********************************************************************
   apb_decode u_apb_decode (
      .i_psel     (i_psel),
      .i_penable  (i_penable),
      .i_pwrite   (i_pwrite),
      .i_paddr    (i_paddr),
      .i_pready   (o_pready),
      .o_sel_gpio (sel_gpio),
      .o_sel_sys  (sel_sys),
      .o_reg_idx  (reg_idx),
      .o_wr_stb   (wr_stb),
      .o_err      (err)
   );

   gpio_bank u_gpio_bank (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_sel      (sel_gpio),
      .i_reg_idx  (reg_idx),
      .i_wr_stb   (wr_stb),
      .i_wdata    (i_pwdata),
      .i_gpio_in  (i_gpio_in),
      .o_rdata    (gpio_rdata),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_gpio_irq (gpio_irq)
   );

   sys_ctrl u_sys_ctrl (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_sel      (sel_sys),
      .i_reg_idx  (reg_idx),
      .i_wr_stb   (wr_stb),
      .i_wdata    (i_pwdata),
      .i_gpio_irq (gpio_irq),
      .o_rdata    (sys_rdata),
      .o_ext_irq  (o_ext_irq)
   );

   read_return u_read_return (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_psel       (i_psel),
      .i_penable    (i_penable),
      .i_sel_gpio   (sel_gpio),
      .i_sel_sys    (sel_sys),
      .i_err        (err),
      .i_gpio_rdata (gpio_rdata),
      .i_sys_rdata  (sys_rdata),
      .o_prdata     (o_prdata),
      .o_pready     (o_pready),
      .o_pslverr    (o_pslverr)
   );

endmodule

//--- verification/tb_clock.sv
module tb_clock (
   output logic clk
);

   timeunit 1ns;
   timeprecision 1ps;

   // 40 ns period
   localparam int HALF_PERIOD = 20;

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

endmodule

//--- verification/periph_asserts.sv
module periph_asserts (
   input logic                           clk,
   input logic                           i_rst_n,
   input logic                           i_psel,
   input logic                           i_penable,
   input logic                           o_pready,
   input logic                           o_pslverr,
   input logic [periph_pkg::IRQ_W-1:0]   o_ext_irq
);

   timeunit 1ns;
   timeprecision 1ps;

   import periph_pkg::*;

   int fail_cnt;

   initial fail_cnt = 0;

   // Ready only in the cycle after an access cycle that still waited
   a_ready_after_access: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_pready |-> $past(i_psel && i_penable && !o_pready))
      else begin
         fail_cnt++;
         $error("o_pready high without a waiting access cycle before it");
      end

   a_err_with_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_pslverr |-> o_pready)
      else begin
         fail_cnt++;
         $error("o_pslverr high while o_pready is low");
      end

   // Compare starts at all ones
   a_timer_quiet: assert property (@(posedge clk)
      $rose(i_rst_n) |-> !o_ext_irq[IRQ_TIMER])
      else begin
         fail_cnt++;
         $error("timer interrupt active right after reset");
      end

endmodule

bind periph_subsys periph_asserts u_periph_asserts (
   .clk       (clk),
   .i_rst_n   (i_rst_n),
   .i_psel    (i_psel),
   .i_penable (i_penable),
   .o_pready  (o_pready),
   .o_pslverr (o_pslverr),
   .o_ext_irq (o_ext_irq)
);

//--- verification/tb_periph_subsys.sv
module tb_periph_subsys;

   timeunit 1ns;
   timeprecision 1ps;

   import soc_map_pkg::*;
   import periph_pkg::*;

   localparam int CLK_PERIOD  = 40;
   localparam int RST_CYCLES  = 5;
   localparam int PIN_SETTLE  = 4;
   localparam int N_XFER      = 50;
   localparam int N_PIN_MOVES = 6;
   localparam int WATCHDOG_CYCLES = RST_CYCLES + N_XFER * 3 + N_PIN_MOVES * PIN_SETTLE + 40;

   logic              clk;
   logic              i_rst_n;
   logic              i_psel;
   logic              i_penable;
   logic              i_pwrite;
   logic [ADDR_W-1:0] i_paddr;
   logic [DATA_W-1:0] i_pwdata;
   logic [DATA_W-1:0] o_prdata;
   logic              o_pready;
   logic              o_pslverr;
   logic [GPIO_W-1:0] i_gpio_in;
   logic [GPIO_W-1:0] o_gpio_out;
   logic [GPIO_W-1:0] o_gpio_oe;
   logic [IRQ_W-1:0]  o_ext_irq;
   logic [DATA_W-1:0] irq_word;

   // Register model
   logic [DATA_W-1:0] m_out;
   logic [DATA_W-1:0] m_oe;
   logic [DATA_W-1:0] m_mask;
   logic [DATA_W-1:0] m_stat;
   logic [DATA_W-1:0] m_in;
   logic [DATA_W-1:0] m_cmp;
   logic              m_sw3;
   logic              m_sw4;

   string             name_q[$];
   logic [DATA_W-1:0] exp_q[$];
   logic [DATA_W-1:0] act_q[$];
   event              rd_pushed;
   int                seed;

   assign irq_word = {{(DATA_W - IRQ_W){1'b0}}, o_ext_irq};

   tb_clock u_clock (
      .clk (clk)
   );

   periph_subsys u_periph_subsys (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_psel     (i_psel),
      .i_penable  (i_penable),
      .i_pwrite   (i_pwrite),
      .i_paddr    (i_paddr),
      .i_pwdata   (i_pwdata),
      .o_prdata   (o_prdata),
      .o_pready   (o_pready),
      .o_pslverr  (o_pslverr),
      .i_gpio_in  (i_gpio_in),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_ext_irq  (o_ext_irq)
   );

   task automatic stop_run();
      $display("Test FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check(input string name, input logic [DATA_W-1:0] exp_val,
                        input logic [DATA_W-1:0] act_val);
      if (act_val !== exp_val) begin
         $display("ERR %s expected %h actual %h", name, exp_val, act_val);
         stop_run();
      end
   endtask

   function automatic logic [ADDR_W-1:0] addr_of(input logic [REGION_W-1:0] region,
                                                 input logic [REG_IDX_W-1:0] idx);
      return {region, 3'b000, idx, 2'b00};
   endfunction

   //*********************************************************************
   // Reference model
   //*********************************************************************
   function automatic logic [DATA_W-1:0] irq_model();
      logic [DATA_W-1:0] vec;
      vec            = '0;
      vec[IRQ_SW3]   = m_sw3;
      vec[IRQ_SW4]   = m_sw4;
      vec[IRQ_GPIO]  = |(m_stat & m_mask);
      // MTIME stays far below all ones, so only a zero compare fires
      vec[IRQ_TIMER] = (m_cmp == '0);
      return vec;
   endfunction

   function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
      logic [REGION_W-1:0]  region;
      logic [REG_IDX_W-1:0] idx;
      logic [DATA_W-1:0]    value;
      region = addr[REGION_MSB:REGION_LSB];
      idx    = addr[REG_IDX_MSB:REG_IDX_LSB];
      value  = '0;
      if (region == REGION_GPIO) begin
         case (idx)
            GPIO_DATA_IN:  value = m_in;
            GPIO_DATA_OUT: value = m_out;
            GPIO_OUT_EN:   value = m_oe;
            GPIO_IRQ_MASK: value = m_mask;
            GPIO_IRQ_STAT: value = m_stat;
            default:       value = '0;
         endcase
      end else if (region == REGION_SYS) begin
         case (idx)
            SYS_MTIMECMP: value = m_cmp;
            SYS_CTRL:     value = {27'b0, m_sw4, m_sw3, 3'b000};
            SYS_IRQ_PEND: value = irq_model();
            default:      value = '0;
         endcase
      end
      return value;
   endfunction

   function automatic void apply_write(input logic [ADDR_W-1:0] addr,
                                       input logic [DATA_W-1:0] data);
      logic [REGION_W-1:0]  region;
      logic [REG_IDX_W-1:0] idx;
      region = addr[REGION_MSB:REGION_LSB];
      idx    = addr[REG_IDX_MSB:REG_IDX_LSB];
      if (region == REGION_GPIO) begin
         case (idx)
            GPIO_DATA_OUT: m_out = data;
            GPIO_OUT_EN:   m_oe = data;
            GPIO_IRQ_MASK: m_mask = data;
            GPIO_IRQ_STAT: m_stat = m_stat & ~data;
            default:       ;
         endcase
      end else if (region == REGION_SYS) begin
         case (idx)
            SYS_MTIMECMP: m_cmp = data;
            SYS_CTRL: begin
               m_sw3 = data[3];
               m_sw4 = data[4];
            end
            default:      ;
         endcase
      end
   endfunction

   //*********************************************************************
   // APB master that starts and ends 2 ns after a rising edge
   //*********************************************************************
   task automatic apb_xfer(input logic write, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data,
                           output logic [DATA_W-1:0] rdata, output logic slverr);
      int waits;
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = write;
      i_paddr   = addr;
      i_pwdata  = data;
      @(posedge clk);
      #2;
      i_penable = 1'b1;
      @(posedge clk);
      #2;
      waits = 1;
      while (!o_pready && waits < 4) begin
         @(posedge clk);
         #2;
         waits++;
      end
      if (!o_pready) begin
         $display("APB transfer to address %h never got o_pready", addr);
         stop_run();
      end
      check("APB wait states", 32'd1, 32'(waits));
      rdata  = o_prdata;
      slverr = o_pslverr;
      @(posedge clk);
      #2;
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
   endtask

   task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      logic [DATA_W-1:0] rd;
      logic              err;
      apb_xfer(1'b1, addr, data, rd, err);
      apply_write(addr, data);
      check("write pslverr", 32'd0, {31'b0, err});
   endtask

   task automatic read_check(input string name, input logic [ADDR_W-1:0] addr);
      logic [DATA_W-1:0] rd;
      logic              err;
      logic              bad;
      bad = (addr[REGION_MSB:REGION_LSB] != REGION_GPIO) &&
            (addr[REGION_MSB:REGION_LSB] != REGION_SYS);
      apb_xfer(1'b0, addr, '0, rd, err);
      name_q.push_back(name);
      exp_q.push_back(ref_read(addr));
      act_q.push_back(rd);
      name_q.push_back($sformatf("%s pslverr", name));
      exp_q.push_back({31'b0, bad});
      act_q.push_back({31'b0, err});
      -> rd_pushed;
   endtask

   task automatic drive_pins(input logic [GPIO_W-1:0] value);
      m_stat    = m_stat | (value & ~m_in);
      m_in      = value;
      i_gpio_in = value;
      repeat (PIN_SETTLE) @(posedge clk);
      #2;
   endtask

   initial begin : compare
      string             name;
      logic [DATA_W-1:0] exp_val;
      logic [DATA_W-1:0] act_val;
      forever begin
         @(rd_pushed);
         while (act_q.size() > 0) begin
            name    = name_q.pop_front();
            exp_val = exp_q.pop_front();
            act_val = act_q.pop_front();
            check(name, exp_val, act_val);
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      stop_run();
   end

   initial begin : stimulus
      int                pin;
      int                other;
      int                k;
      logic [DATA_W-1:0] w;
      logic [DATA_W-1:0] t1;
      logic [DATA_W-1:0] t2;
      logic [DATA_W-1:0] rd;
      logic              err;
      seed      = 32'h71ef36b9;
      i_rst_n   = 1'b0;
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
      i_paddr   = '0;
      i_pwdata  = '0;
      i_gpio_in = '0;
      m_out     = '0;
      m_oe      = '0;
      m_mask    = '0;
      m_stat    = '0;
      m_in      = '0;
      m_cmp     = '1;
      m_sw3     = 1'b0;
      m_sw4     = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #2;
      i_rst_n = 1'b1;

      // GPIO output registers
      write_reg(addr_of(REGION_GPIO, GPIO_DATA_OUT), $random(seed));
      write_reg(addr_of(REGION_GPIO, GPIO_OUT_EN), $random(seed));
      write_reg(addr_of(REGION_GPIO, GPIO_IRQ_MASK), $random(seed));
      check("gpio_out pins", m_out, o_gpio_out);
      check("gpio_oe pins", m_oe, o_gpio_oe);
      read_check("DATA_OUT", addr_of(REGION_GPIO, GPIO_DATA_OUT));
      read_check("OUT_EN", addr_of(REGION_GPIO, GPIO_OUT_EN));
      read_check("IRQ_MASK", addr_of(REGION_GPIO, GPIO_IRQ_MASK));

      // Synchronised input
      drive_pins($random(seed));
      read_check("DATA_IN", addr_of(REGION_GPIO, GPIO_DATA_IN));
      read_check("IRQ_STAT random pins", addr_of(REGION_GPIO, GPIO_IRQ_STAT));

      // Edge interrupt on one masked pin, then one unmasked pin
      pin   = $random(seed) & 31;
      other = (pin + 1) % GPIO_W;
      write_reg(addr_of(REGION_GPIO, GPIO_IRQ_MASK), 32'h1 << pin);
      drive_pins('0);
      write_reg(addr_of(REGION_GPIO, GPIO_IRQ_STAT), '1);
      check("irq idle", irq_model(), irq_word);
      drive_pins(32'h1 << pin);
      check("irq masked edge", irq_model(), irq_word);
      read_check("IRQ_STAT edge", addr_of(REGION_GPIO, GPIO_IRQ_STAT));
      write_reg(addr_of(REGION_GPIO, GPIO_IRQ_STAT), 32'h1 << pin);
      check("irq cleared", irq_model(), irq_word);
      read_check("IRQ_STAT cleared", addr_of(REGION_GPIO, GPIO_IRQ_STAT));
      drive_pins((32'h1 << pin) | (32'h1 << other));
      check("irq unmasked edge", irq_model(), irq_word);
      read_check("IRQ_STAT unmasked", addr_of(REGION_GPIO, GPIO_IRQ_STAT));

      // Timer compare
      write_reg(addr_of(REGION_SYS, SYS_MTIMECMP), '0);
      check("timer raised", irq_model(), irq_word);
      read_check("IRQ_PEND timer", addr_of(REGION_SYS, SYS_IRQ_PEND));
      write_reg(addr_of(REGION_SYS, SYS_MTIMECMP), '1);
      check("timer lowered", irq_model(), irq_word);
      read_check("MTIMECMP", addr_of(REGION_SYS, SYS_MTIMECMP));
      apb_xfer(1'b0, addr_of(REGION_SYS, SYS_MTIME), '0, t1, err);
      apb_xfer(1'b0, addr_of(REGION_SYS, SYS_MTIME), '0, t2, err);
      check("MTIME increasing", 32'd1, {31'b0, t2 > t1});

      // Software interrupt bits in all four combinations
      for (k = 0; k < 4; k++) begin
         w = ($random(seed) & ~32'h18) | (32'(k) << 3);
         write_reg(addr_of(REGION_SYS, SYS_CTRL), w);
         check("sw irq bits", irq_model(), irq_word);
         read_check("CTRL", addr_of(REGION_SYS, SYS_CTRL));
         read_check("IRQ_PEND sw", addr_of(REGION_SYS, SYS_IRQ_PEND));
      end

      // Unmapped region 2
      apb_xfer(1'b1, addr_of(4'd2, GPIO_DATA_OUT), $random(seed), rd, err);
      check("region 2 write pslverr", 32'd1, {31'b0, err});
      read_check("region 2 read", addr_of(4'd2, GPIO_DATA_OUT));
      for (k = 0; k < 5; k++) begin
         read_check($sformatf("GPIO reg %0d unchanged", k), addr_of(REGION_GPIO, 3'(k)));
      end
      for (k = 1; k < 4; k++) begin
         read_check($sformatf("SYS reg %0d unchanged", k), addr_of(REGION_SYS, 3'(k)));
      end
      check("gpio_out unchanged", m_out, o_gpio_out);
      check("gpio_oe unchanged", m_oe, o_gpio_oe);

      #1;
      if (act_q.size() == 0 && u_periph_subsys.u_periph_asserts.fail_cnt == 0) begin
         $display("Test OK");
         $finish;
      end else begin
         $display("Reads left unchecked or assertions failed");
         stop_run();
      end
   end

endmodule

//--- flist.f
design/soc_map_pkg.sv
design/periph_pkg.sv
design/apb_decode.sv
design/gpio_bank.sv
design/sys_ctrl.sv
design/read_return.sv
design/periph_subsys.sv
verification/tb_clock.sv
verification/periph_asserts.sv
verification/tb_periph_subsys.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_periph_subsys \
   -f flist.f \
   -o sim_periph_subsys

sim_out=$(./obj_dir/sim_periph_subsys 2>&1 || true)
echo "$sim_out"

echo "$sim_out" | grep -qx "Test OK"
